//--- logic/uart_pkg.sv
// UART shared definitions
package uart_pkg;

    localparam int data_w = 8;
    localparam int samples_per_bit = 8;    // Baud ticks per serial bit
    localparam int half_bit = 4;           // Start edge to mid start bit
    localparam int fifo_aw = 4;
    localparam int fifo_depth = 2 ** fifo_aw;
    localparam int prescale_w = 16;
    localparam int tick_w = $clog2(samples_per_bit);
    localparam int bit_cnt_w = $clog2(data_w);
    localparam logic [tick_w-1:0] last_tick = tick_w'(samples_per_bit - 1);
    localparam logic [bit_cnt_w-1:0] last_bit = bit_cnt_w'(data_w - 1);

    typedef logic [data_w-1:0] data_t;

    typedef enum logic [2:0] {
        par_none    = 3'b000,
        par_odd     = 3'b001,
        par_even    = 3'b010,
        par_sticky0 = 3'b100,
        par_sticky1 = 3'b101
    } parity_e;

    typedef struct packed {
        data_t data;
        logic  parity_error;
        logic  frame_error;
    } rx_word_t;

    // Common frame sequence for both directions
    typedef enum logic [2:0] {
        st_idle, st_start, st_data, st_parity, st_stop0, st_stop1
    } frame_state_e;

    function automatic logic has_parity(parity_e mode);
        return mode inside {par_odd, par_even, par_sticky0, par_sticky1};
    endfunction

    function automatic logic parity_bit(parity_e mode, data_t data);
        logic bit_val;
        case (mode)
            par_odd:     bit_val = ~^data;    // Total ones count odd
            par_even:    bit_val = ^data;
            par_sticky1: bit_val = 1'b1;
            default:     bit_val = 1'b0;      // Sticky 0 and unused codes
        endcase
        return bit_val;
    endfunction

endpackage

//--- logic/uart_baud_gen.sv
// UART baud tick generator
`timescale 1ns/1ps

module uart_baud_gen import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  en,
    input  logic [prescale_w-1:0] prescaler,
    output logic                  baud_tick
);

    logic [prescale_w-1:0] count;
    logic                  at_top;

    assign at_top = (count == prescaler);
    assign baud_tick = en && at_top;    // One tick per prescaler+1 clocks

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            count <= '0;
        end else if (en) begin
            count <= at_top ? '0 : count + 1'b1;
        end
    end

    a_no_tick_when_off: assert property (
        @(posedge clk) disable iff (!resetn) !en |-> !baud_tick
    ) else $error("baud_tick high while en is low");

endmodule

//--- logic/uart_fifo.sv
// First-word-fall-through FIFO
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; #(
    parameter type payload_t = data_t
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     wr,
    input  payload_t wdata,
    input  logic     rd,
    output payload_t rdata,
    output logic     empty,
    output logic     full
);

    payload_t             mem [fifo_depth];
    logic [fifo_aw-1:0]   wr_ptr;
    logic [fifo_aw-1:0]   rd_ptr;
    logic [fifo_aw:0]     count;    // One bit wider to hold depth
    logic                 do_wr;
    logic                 do_rd;

    // Overflowing writes and underflowing reads are dropped here
    assign do_wr = wr && !full;
    assign do_rd = rd && !empty;

    assign empty = (count == '0);
    assign full  = (count == (fifo_aw + 1)'(fifo_depth));
    assign rdata = mem[rd_ptr];    // Head shown without a read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;    // Wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Idle or simultaneous
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!resetn) count <= (fifo_aw + 1)'(fifo_depth)
    ) else $error("FIFO count beyond depth");

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (!resetn) !(empty && full)
    ) else $error("FIFO empty and full together");

endmodule

//--- logic/uart_tx.sv
// UART transmitter
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    baud_tick,
    input  parity_e parity_type,
    input  logic    two_stop_bits,
    input  data_t   head,
    input  logic    head_valid,
    output logic    pop,
    output logic    tx
);

    frame_state_e         state;
    logic [tick_w-1:0]    tick_cnt;
    logic [bit_cnt_w-1:0] bit_cnt;
    data_t                shift_r;
    logic                 par_r;
    logic                 bit_end;

    assign bit_end = baud_tick && (tick_cnt == last_tick);
    assign pop = (state == st_idle) && head_valid && baud_tick;    // Capture and pop on a tick

    // Byte and its parity taken at capture
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_r <= head;
            par_r   <= parity_bit(parity_type, head);
        end else if (state == st_data && bit_end) begin
            shift_r <= shift_r >> 1;    // LSB first
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (state == st_idle) begin
            tick_cnt <= '0;
        end else if (baud_tick) begin
            tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= st_idle;
            bit_cnt <= '0;
            tx      <= 1'b1;    // Line idles high
        end else begin
            case (state)
                st_idle: if (head_valid && baud_tick) begin
                    state <= st_start;
                    tx    <= 1'b0;    // Start bit from next cycle
                end
                st_start: if (bit_end) begin
                    state   <= st_data;
                    bit_cnt <= '0;
                    tx      <= shift_r[0];
                end
                st_data: if (bit_end) begin
                    if (bit_cnt == last_bit) begin
                        state <= has_parity(parity_type) ? st_parity : st_stop0;
                        tx    <= has_parity(parity_type) ? par_r : 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx      <= shift_r[1];    // Next bit before shift
                    end
                end
                st_parity: if (bit_end) begin
                    state <= st_stop0;
                    tx    <= 1'b1;
                end
                st_stop0: if (bit_end) begin
                    state <= two_stop_bits ? st_stop1 : st_idle;
                end
                st_stop1: if (bit_end) begin
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Capture only from idle with data, frame follows
    a_pop_from_idle: assert property (
        @(posedge clk) disable iff (!resetn)
        pop |-> ((state == st_idle) && head_valid) ##1 (state == st_start)
    ) else $error("pop outside idle or without a frame start");

endmodule

//--- logic/uart_rx.sv
// UART receiver
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic     clk,
    input  logic     resetn,
    input  logic     baud_tick,
    input  parity_e  parity_type,
    input  logic     two_stop_bits,
    input  logic     rx,
    output logic     word_valid,
    output rx_word_t word
);

    logic                 rx_meta;
    logic                 rx_s;
    frame_state_e         state;
    logic [tick_w-1:0]    tick_cnt;
    logic [bit_cnt_w-1:0] bit_cnt;
    data_t                shift_r;
    logic                 perr_r;
    logic                 ferr_r;
    logic                 bit_end;
    logic                 half_end;

    assign bit_end  = baud_tick && (tick_cnt == last_tick);
    assign half_end = baud_tick && (tick_cnt == tick_w'(half_bit - 1));

    // Mid sample of the final stop bit
    assign word_valid = bit_end &&
        ((state == st_stop1) || (state == st_stop0 && !two_stop_bits));

    assign word.data         = shift_r;
    assign word.parity_error = perr_r;
    assign word.frame_error  = ferr_r || !rx_s;    // Includes current stop sample

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_data && bit_end) begin
            shift_r <= {rx_s, shift_r[data_w-1:1]};    // LSB arrives first
        end
    end

    // Realigned to mid bit once the start is confirmed
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tick_cnt <= '0;
        end else if (state == st_idle) begin
            tick_cnt <= '0;
        end else if (baud_tick) begin
            if (bit_end || (state == st_start && half_end)) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state   <= st_idle;
            bit_cnt <= '0;
            perr_r  <= 1'b0;
            ferr_r  <= 1'b0;
        end else begin
            case (state)
                st_idle: if (!rx_s) begin
                    state <= st_start;    // Falling edge seen
                end
                st_start: if (half_end) begin
                    perr_r  <= 1'b0;
                    ferr_r  <= 1'b0;
                    bit_cnt <= '0;
                    state   <= rx_s ? st_idle : st_data;    // Glitch returns to idle
                end
                st_data: if (bit_end) begin
                    if (bit_cnt == last_bit) begin
                        state <= has_parity(parity_type) ? st_parity : st_stop0;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_parity: if (bit_end) begin
                    perr_r <= (rx_s != parity_bit(parity_type, shift_r));
                    state  <= st_stop0;
                end
                st_stop0: if (bit_end) begin
                    ferr_r <= !rx_s;
                    state  <= two_stop_bits ? st_stop1 : st_idle;
                end
                st_stop1: if (bit_end) begin
                    state <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    a_single_valid: assert property (
        @(posedge clk) disable iff (!resetn) word_valid |=> !word_valid
    ) else $error("word_valid high on consecutive cycles");

endmodule

//--- logic/uart_top.sv
// UART top level
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  en,
    input  logic [prescale_w-1:0] prescaler,
    input  parity_e               parity_type,
    input  logic                  two_stop_bits,
    input  logic                  wr,
    input  data_t                 wdata,
    output logic                  tx_empty,
    output logic                  tx_full,
    input  logic                  rd,
    output data_t                 rdata,
    output logic                  rx_parity_error,
    output logic                  rx_frame_error,
    output logic                  rx_empty,
    output logic                  rx_full,
    output logic                  overrun,
    input  logic                  rx,
    output logic                  tx
);

    logic     baud_tick;
    data_t    tx_head;
    logic     tx_pop;
    logic     word_valid;
    rx_word_t rx_word;
    rx_word_t rx_head;

    assign overrun = word_valid && rx_full;    // Frame dropped by full RX FIFO

    assign rdata           = rx_head.data;
    assign rx_parity_error = rx_head.parity_error;
    assign rx_frame_error  = rx_head.frame_error;

    uart_baud_gen u_baud_gen (
        .clk(clk), .resetn(resetn), .en(en),
        .prescaler(prescaler), .baud_tick(baud_tick)
    );

    uart_fifo #(.payload_t(data_t)) u_tx_fifo (
        .clk(clk), .resetn(resetn), .wr(wr), .wdata(wdata), .rd(tx_pop),
        .rdata(tx_head), .empty(tx_empty), .full(tx_full)
    );

    uart_tx u_tx (
        .clk(clk), .resetn(resetn), .baud_tick(baud_tick),
        .parity_type(parity_type), .two_stop_bits(two_stop_bits),
        .head(tx_head), .head_valid(!tx_empty), .pop(tx_pop), .tx(tx)
    );

    uart_rx u_rx (
        .clk(clk), .resetn(resetn), .baud_tick(baud_tick),
        .parity_type(parity_type), .two_stop_bits(two_stop_bits),
        .rx(rx), .word_valid(word_valid), .word(rx_word)
    );

    uart_fifo #(.payload_t(rx_word_t)) u_rx_fifo (
        .clk(clk), .resetn(resetn), .wr(word_valid), .wdata(rx_word), .rd(rd),
        .rdata(rx_head), .empty(rx_empty), .full(rx_full)
    );

endmodule

//--- dv/uart_tb.sv
// UART testbench
`timescale 1ns/1ps

module uart_tb import uart_pkg::*; ();

    localparam int bit_clks = 16;             // Prescaler 1 gives two clocks per tick
    localparam int limit = 40 * bit_clks;
    localparam logic [1:0] inj_none = 2'd0;
    localparam logic [1:0] inj_par = 2'd1;    // Parity bit inverted
    localparam logic [1:0] inj_stop = 2'd2;   // First stop bit low

    typedef struct packed {
        data_t      data;
        logic       rnd;                      // Data replaced by a random byte
        parity_e    mode;
        logic       two_stop;
        logic [1:0] inj;
        logic [1:0] err;                      // Expected parity and frame error
    } row_t;

    logic                  clk = 1'b0, resetn = 1'b0, en = 1'b1;
    logic [prescale_w-1:0] prescaler = 16'd1;
    parity_e               parity_type = par_none;
    logic                  two_stop_bits = 1'b0, wr = 1'b0, rd = 1'b0;
    data_t                 wdata = '0;
    logic                  line_drive = 1'b1;    // rx held high through reset
    logic                  line_val = 1'b1;
    logic                  rx, tx, tx_empty, tx_full, rx_empty, rx_full, overrun;
    logic                  rx_parity_error, rx_frame_error;
    data_t                 rdata;
    logic [2:0]            flags;
    int                    errors = 0, checks = 0, tests = 0, overruns = 0;
    data_t                 sent [$];

    // Columns are data, random flag, parity mode, two stops, injection and expected errors
    row_t rows [16] = '{
        {8'h55, 1'b0, par_none,    1'b0, inj_none, 2'b00},
        {8'h00, 1'b1, par_none,    1'b1, inj_none, 2'b00},
        {8'hA3, 1'b0, par_odd,     1'b0, inj_none, 2'b00},
        {8'h00, 1'b1, par_odd,     1'b1, inj_none, 2'b00},
        {8'h81, 1'b0, par_even,    1'b0, inj_none, 2'b00},
        {8'h00, 1'b1, par_even,    1'b1, inj_none, 2'b00},
        {8'hFF, 1'b0, par_sticky0, 1'b0, inj_none, 2'b00},
        {8'h00, 1'b1, par_sticky0, 1'b1, inj_none, 2'b00},
        {8'h3C, 1'b0, par_sticky1, 1'b0, inj_none, 2'b00},
        {8'h00, 1'b1, par_sticky1, 1'b1, inj_none, 2'b00},
        {8'h5A, 1'b0, par_odd,     1'b0, inj_par,  2'b10},
        {8'h00, 1'b1, par_even,    1'b1, inj_par,  2'b10},
        {8'hC3, 1'b0, par_sticky0, 1'b0, inj_par,  2'b10},
        {8'h00, 1'b1, par_sticky1, 1'b0, inj_par,  2'b10},
        {8'hE7, 1'b0, par_none,    1'b1, inj_stop, 2'b01},
        {8'h00, 1'b1, par_even,    1'b1, inj_stop, 2'b01}
    };

    uart_top u_dut (.*);

    assign rx = line_drive ? line_val : tx;    // Loopback unless a frame is injected
    assign flags = {overruns != 0, rx_full, !rx_empty};

    always #50 clk = ~clk;

    always @(negedge clk) begin
        if (resetn && overrun) begin
            overruns <= overruns + 1;
        end
    end

    function automatic logic expected_parity(parity_e mode, data_t d);
        case (mode)
            par_odd:     return ~^d;    // Ones count odd with the parity bit
            par_even:    return ^d;
            par_sticky1: return 1'b1;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // Flag index 0 rx not empty, 1 rx_full, 2 overrun seen
    task automatic wait_for(input int idx, input int max_clks, input string what);
        int n;
        n = 0;
        while (!flags[idx] && n < max_clks) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!flags[idx]) begin
            errors++;
            $display("Timeout at %0t: %s did not happen in time", $time, what);
        end
    endtask

    task automatic pulse(input logic w, input logic r, input data_t d);
        wr = w;
        rd = r;
        wdata = d;
        @(posedge clk);
        #1;
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic hold(input logic b, input int bits);
        line_val = b;
        repeat (bits * bit_clks) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input row_t r);
        int i;
        line_drive = 1'b1;
        hold(1'b0, 1);
        for (i = 0; i < data_w; i++) begin
            hold(r.data[i], 1);    // LSB first
        end
        if (r.mode != par_none) begin
            hold(expected_parity(r.mode, r.data) ^ (r.inj == inj_par), 1);
        end
        hold(r.inj != inj_stop, 1);
        if (r.two_stop) begin
            hold(1'b1, 1);
        end
        line_drive = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("%s: %s", name, (errors == err_start) ? "ok" : "errors");
    endtask

    task automatic write_burst(input int n);
        data_t d;
        int    i;
        sent.delete();
        for (i = 0; i < n; i++) begin
            d = data_t'($urandom);
            sent.push_back(d);
            pulse(1'b1, 1'b0, d);
        end
    endtask

    task automatic read_back(input int n, input logic wait_each);
        int i;
        for (i = 0; i < n; i++) begin
            if (wait_each) begin
                wait_for(0, limit, "rx_empty low");
            end
            check("rdata", sent[i], rdata);
            pulse(1'b0, 1'b1, '0);
        end
    endtask

    task automatic run_row(input row_t r);
        parity_type = r.mode;
        two_stop_bits = r.two_stop;
        if (r.inj == inj_none) begin
            pulse(1'b1, 1'b0, r.data);
        end else begin
            send_frame(r);
        end
        wait_for(0, limit, "rx_empty low after a frame");
        check("rdata", r.data, rdata);
        check("rx_parity_error", r.err[1], rx_parity_error);
        check("rx_frame_error", r.err[0], rx_frame_error);
        pulse(1'b0, 1'b1, '0);
        hold(1'b1, 2);    // Rest of the last stop bit
    endtask

    initial begin
        row_t r;
        int   i;
        int   err_start;
        void'($urandom(56720));
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        line_drive = 1'b0;

        err_start = errors;
        check("tx", 1, tx);
        check("tx_empty", 1, tx_empty);
        check("rx_empty", 1, rx_empty);
        check("tx_full", 0, tx_full);
        check("rx_full", 0, rx_full);
        check("overrun", 0, overrun);
        finish_test("reset state", err_start);

        for (i = 0; i < 16; i++) begin
            r = rows[i];
            if (r.rnd) begin
                r.data = data_t'($urandom);
            end
            err_start = errors;
            run_row(r);
            finish_test($sformatf("row %0d parity %0d stops %0d injection %0d",
                i, r.mode, r.two_stop + 1, r.inj), err_start);
        end

        // Ticks stopped, so the transmitter stays idle and the FIFO fills
        err_start = errors;
        parity_type = par_none;
        two_stop_bits = 1'b0;
        en = 1'b0;
        write_burst(16);
        check("tx_full", 1, tx_full);
        pulse(1'b1, 1'b0, 8'hA5);    // Dropped by the full FIFO
        check("tx_full", 1, tx_full);
        check("tx", 1, tx);
        en = 1'b1;
        read_back(16, 1'b1);
        hold(1'b1, 12);              // Longer than one more frame
        check("rx_empty", 1, rx_empty);
        finish_test("tx fifo full", err_start);

        err_start = errors;
        check("overrun count", 0, overruns);
        write_burst(17);
        wait_for(1, 17 * 12 * bit_clks, "rx_full high");
        wait_for(2, limit, "overrun pulse");
        hold(1'b1, 2);
        check("overrun count", 1, overruns);
        check("rx_full", 1, rx_full);
        read_back(16, 1'b0);
        check("rx_empty", 1, rx_empty);
        finish_test("rx overrun", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/uart_pkg.sv
logic/uart_baud_gen.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
dv/uart_tb.sv
